// File: core_sizes_pkg.sv
package core_sizes_pkg;

    localparam int QUEUE_DEPTH = 4;     // also the sender's starting credits
    localparam int QUEUE_IDX_W = $clog2(QUEUE_DEPTH);
    localparam int ROB_DEPTH   = 16;
    localparam int ROB_IDX_W   = $clog2(ROB_DEPTH);
    localparam int PHYS_REGS   = 48;
    localparam int PREG_W      = $clog2(PHYS_REGS);
    localparam int ARCH_REGS   = 32;
    localparam int AREG_W      = $clog2(ARCH_REGS);
    localparam int FREE_DEPTH  = PHYS_REGS - ARCH_REGS;    // unmapped after reset
    localparam int FREE_IDX_W  = $clog2(FREE_DEPTH);
    localparam int MUL_STAGES  = 3;

endpackage

// File: core_types_pkg.sv
package core_types_pkg;
    import core_sizes_pkg::*;

    // rv32 major opcodes and funct7 values the decoder looks at
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] F7_ALT     = 7'b0100000;
    localparam logic [6:0] F7_MULDIV  = 7'b0000001;

    typedef enum logic [2:0] {
        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_MUL
    } op_e;

    typedef struct packed {
        op_e               op;
        logic [AREG_W-1:0] rd;
        logic [AREG_W-1:0] rs1;
        logic [AREG_W-1:0] rs2;
        logic [11:0]       imm;
        logic              use_rs2;
    } decoded_t;

    typedef struct packed {
        logic                 valid;
        op_e                  op;
        logic [31:0]          rs1_val;
        logic [31:0]          rs2_val;
        logic [11:0]          imm;
        logic [PREG_W-1:0]    pd;
        logic [ROB_IDX_W-1:0] rob_idx;
    } issue_t;

    typedef struct packed {
        logic                 valid;
        logic [PREG_W-1:0]    preg;
        logic [ROB_IDX_W-1:0] rob_idx;
        logic [31:0]          value;
    } cdb_t;

    typedef struct packed {
        logic              done;
        logic [AREG_W-1:0] rd;
        logic [PREG_W-1:0] pd;
        logic [PREG_W-1:0] old_pd;     // freed when this entry commits
    } rob_entry_t;

    typedef struct packed {
        logic       valid;
        rob_entry_t entry;
    } alloc_t;

    typedef struct packed {
        logic              valid;
        logic [AREG_W-1:0] rd;
        logic [31:0]       value;
    } commit_t;

endpackage

// File: inst_queue.sv
module inst_queue
import core_sizes_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    input  logic        deq_i,
    output logic [31:0] head_o,
    output logic        not_empty_o,
    output logic        credit_o
);

    logic [31:0]            mem [QUEUE_DEPTH];
    logic [QUEUE_IDX_W-1:0] rd_ptr;
    logic [QUEUE_IDX_W-1:0] wr_ptr;
    logic [QUEUE_IDX_W:0]   count;

    assign head_o      = mem[rd_ptr];
    assign not_empty_o = (count != '0);

    always_ff @(posedge clk) begin
        if (inst_valid_i) begin
            mem[wr_ptr] <= inst_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (inst_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count + {{QUEUE_IDX_W{1'b0}}, inst_valid_i}
                              - {{QUEUE_IDX_W{1'b0}}, deq_i};
            credit_o <= deq_i;     // one credit back per dequeued slot
        end
    end

    // a sender that respects its credits never finds the queue full
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        inst_valid_i |-> (count < QUEUE_DEPTH));

endmodule

// File: rename_dispatch.sv
module rename_dispatch
import core_sizes_pkg::*, core_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [31:0]          head_i,
    input  logic                 not_empty_i,
    input  logic                 rob_full_i,
    input  logic [ROB_IDX_W-1:0] rob_idx_i,
    input  cdb_t                 cdb_i,
    input  logic                 rs1_ready_i,
    input  logic                 rs2_ready_i,
    input  logic [31:0]          rs1_val_i,
    input  logic [31:0]          rs2_val_i,
    input  logic                 mul_tail_busy_i,
    input  logic                 free_valid_i,
    input  logic [PREG_W-1:0]    free_preg_i,
    output logic                 deq_o,
    output logic [PREG_W-1:0]    rs1_preg_o,
    output logic [PREG_W-1:0]    rs2_preg_o,
    output alloc_t               alloc_o,
    output issue_t               issue_o
);

    decoded_t              dec;
    logic [PREG_W-1:0]     rat [ARCH_REGS];
    logic [PREG_W-1:0]     fl_mem [FREE_DEPTH];
    logic [FREE_IDX_W-1:0] fl_head;
    logic [FREE_IDX_W-1:0] fl_tail;
    logic [FREE_IDX_W:0]   fl_count;
    logic [PREG_W-1:0]     new_preg;
    logic                  writes_rd;
    logic                  rs1_ok;
    logic                  rs2_ok;
    logic                  dispatch;
    logic                  fl_pop;

    always_comb begin
        dec.rd      = head_i[11:7];
        dec.rs1     = head_i[19:15];
        dec.rs2     = head_i[24:20];
        dec.imm     = head_i[31:20];
        dec.use_rs2 = (head_i[6:0] != OPC_OP_IMM);
        if (head_i[6:0] == OPC_OP_IMM) begin
            dec.op = OP_ADDI;
        end else if (head_i[31:25] == F7_MULDIV) begin
            dec.op = OP_MUL;
        end else if (head_i[31:25] == F7_ALT) begin
            dec.op = OP_SUB;
        end else begin
            case (head_i[14:12])
                3'b100:  dec.op = OP_XOR;
                3'b110:  dec.op = OP_OR;
                3'b111:  dec.op = OP_AND;
                default: dec.op = OP_ADD;
            endcase
        end
    end

    assign rs1_preg_o = rat[dec.rs1];
    assign rs2_preg_o = rat[dec.rs2];

    // ready in the file, or arriving on the bus right now
    assign rs1_ok = rs1_ready_i || (cdb_i.valid && cdb_i.preg == rs1_preg_o);
    assign rs2_ok = !dec.use_rs2 || rs2_ready_i
                  || (cdb_i.valid && cdb_i.preg == rs2_preg_o);

    assign writes_rd = (dec.rd != '0);
    assign new_preg  = writes_rd ? fl_mem[fl_head] : '0;   // x0 results go to preg 0

    assign dispatch = not_empty_i && !rob_full_i && rs1_ok && rs2_ok
                    && !(writes_rd && fl_count == '0)
                    && !(dec.op != OP_MUL && mul_tail_busy_i);
    assign fl_pop   = dispatch && writes_rd;
    assign deq_o    = dispatch;

    always_comb begin
        alloc_o.valid        = dispatch;
        alloc_o.entry.done   = 1'b0;
        alloc_o.entry.rd     = dec.rd;
        alloc_o.entry.pd     = new_preg;
        alloc_o.entry.old_pd = rat[dec.rd];

        issue_o.valid   = dispatch;
        issue_o.op      = dec.op;
        issue_o.rs1_val = rs1_ready_i ? rs1_val_i : cdb_i.value;
        issue_o.rs2_val = rs2_ready_i ? rs2_val_i : cdb_i.value;
        issue_o.imm     = dec.imm;
        issue_o.pd      = new_preg;
        issue_o.rob_idx = rob_idx_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat[i] <= PREG_W'(i);
            end
        end else if (fl_pop) begin
            rat[dec.rd] <= new_preg;
        end
    end

    // free list starts out holding the upper registers
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FREE_DEPTH; i++) begin
                fl_mem[i] <= PREG_W'(ARCH_REGS + i);
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= FREE_DEPTH[FREE_IDX_W:0];
        end else begin
            if (free_valid_i) begin
                fl_mem[fl_tail] <= free_preg_i;
                fl_tail         <= fl_tail + 1'b1;
            end
            if (fl_pop) begin
                fl_head <= fl_head + 1'b1;
            end
            fl_count <= fl_count + {{FREE_IDX_W{1'b0}}, free_valid_i}
                                 - {{FREE_IDX_W{1'b0}}, fl_pop};
        end
    end

    // rob only returns registers that were handed out earlier
    a_fl_no_overflow: assert property (@(posedge clk) disable iff (rst)
        (free_valid_i && !fl_pop) |-> (fl_count < FREE_DEPTH));

endmodule

// File: phys_regfile.sv
module phys_regfile
import core_sizes_pkg::*, core_types_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  cdb_t              cdb_i,
    input  logic [PREG_W-1:0] rs1_preg_i,
    input  logic [PREG_W-1:0] rs2_preg_i,
    input  logic              clear_valid_i,
    input  logic [PREG_W-1:0] clear_preg_i,
    input  logic [PREG_W-1:0] commit_preg_i,
    output logic [31:0]       rs1_val_o,
    output logic [31:0]       rs2_val_o,
    output logic              rs1_ready_o,
    output logic              rs2_ready_o,
    output logic [31:0]       commit_val_o
);

    logic [31:0]          vals [PHYS_REGS];
    logic [PHYS_REGS-1:0] ready;

    assign rs1_val_o    = vals[rs1_preg_i];
    assign rs2_val_o    = vals[rs2_preg_i];
    assign rs1_ready_o  = ready[rs1_preg_i];
    assign rs2_ready_o  = ready[rs2_preg_i];
    assign commit_val_o = vals[commit_preg_i];  // rob's read port

    // preg 0 backs x0, stays zero and ready
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHYS_REGS; i++) begin
                vals[i] <= '0;
            end
            ready <= '1;
        end else begin
            if (cdb_i.valid && cdb_i.preg != '0) begin
                vals[cdb_i.preg]  <= cdb_i.value;
                ready[cdb_i.preg] <= 1'b1;
            end
            if (clear_valid_i && clear_preg_i != '0) begin
                ready[clear_preg_i] <= 1'b0;   // new destination, result pending
            end
        end
    end

endmodule

// File: exec_units.sv
module exec_units
import core_sizes_pkg::*, core_types_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  issue_t issue_i,
    output cdb_t   cdb_o,
    output logic   mul_tail_busy_o
);

    cdb_t        mul_q [MUL_STAGES-1];     // final stage is the bus register
    logic [31:0] imm_ext;
    logic [31:0] alu_res;
    logic        alu_go;

    assign imm_ext         = {{20{issue_i.imm[11]}}, issue_i.imm};
    assign alu_go          = issue_i.valid && (issue_i.op != OP_MUL);
    assign mul_tail_busy_o = mul_q[MUL_STAGES-2].valid;

    always_comb begin
        case (issue_i.op)
            OP_SUB:  alu_res = issue_i.rs1_val - issue_i.rs2_val;
            OP_AND:  alu_res = issue_i.rs1_val & issue_i.rs2_val;
            OP_OR:   alu_res = issue_i.rs1_val | issue_i.rs2_val;
            OP_XOR:  alu_res = issue_i.rs1_val ^ issue_i.rs2_val;
            OP_ADDI: alu_res = issue_i.rs1_val + imm_ext;
            default: alu_res = issue_i.rs1_val + issue_i.rs2_val;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MUL_STAGES-1; i++) begin
                mul_q[i].valid <= 1'b0;
            end
            cdb_o.valid <= 1'b0;
        end else begin
            mul_q[0].valid   <= issue_i.valid && (issue_i.op == OP_MUL);
            mul_q[0].preg    <= issue_i.pd;
            mul_q[0].rob_idx <= issue_i.rob_idx;
            mul_q[0].value   <= issue_i.rs1_val * issue_i.rs2_val;   // low word only
            for (int i = 1; i < MUL_STAGES-1; i++) begin
                mul_q[i] <= mul_q[i-1];
            end
            if (alu_go) begin
                cdb_o <= '{valid: 1'b1, preg: issue_i.pd,
                           rob_idx: issue_i.rob_idx, value: alu_res};
            end else begin
                cdb_o <= mul_q[MUL_STAGES-2];
            end
        end
    end

    // dispatch must hold ALU ops back, else a MUL result is dropped
    a_one_result: assert property (@(posedge clk) disable iff (rst)
        alu_go |-> !mul_q[MUL_STAGES-2].valid);

endmodule

// File: rob.sv
module rob
import core_sizes_pkg::*, core_types_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  alloc_t               alloc_i,
    input  cdb_t                 cdb_i,
    input  logic [31:0]          commit_val_i,
    output logic                 full_o,
    output logic [ROB_IDX_W-1:0] rob_idx_o,
    output logic [PREG_W-1:0]    commit_preg_o,
    output commit_t              commit_o,
    output logic                 free_valid_o,
    output logic [PREG_W-1:0]    free_preg_o
);

    rob_entry_t           entries [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] busy;     // allocated and not yet committed
    logic [ROB_IDX_W-1:0] head;
    logic [ROB_IDX_W-1:0] tail;
    logic [ROB_IDX_W:0]   count;
    rob_entry_t           head_e;
    logic                 retire;

    assign head_e        = entries[head];
    assign retire        = busy[head] && head_e.done;
    assign full_o        = (count == ROB_DEPTH);
    assign rob_idx_o     = tail;
    assign commit_preg_o = head_e.pd;
    assign free_valid_o  = retire && (head_e.rd != '0);
    assign free_preg_o   = head_e.old_pd;

    always_ff @(posedge clk) begin
        if (alloc_i.valid) begin
            entries[tail] <= alloc_i.entry;
        end
        if (cdb_i.valid) begin
            entries[cdb_i.rob_idx].done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy           <= '0;
            head           <= '0;
            tail           <= '0;
            count          <= '0;
            commit_o.valid <= 1'b0;
        end else begin
            if (alloc_i.valid) begin
                busy[tail] <= 1'b1;
                tail       <= tail + 1'b1;
            end
            if (retire) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            count <= count + {{ROB_IDX_W{1'b0}}, alloc_i.valid}
                           - {{ROB_IDX_W{1'b0}}, retire};
            commit_o.valid <= retire;
            commit_o.rd    <= head_e.rd;
            commit_o.value <= (head_e.rd == '0) ? '0 : commit_val_i;
        end
    end

    // results only come back for entries still in flight
    a_cdb_hits_busy: assert property (@(posedge clk) disable iff (rst)
        cdb_i.valid |-> busy[cdb_i.rob_idx]);

endmodule

// File: cpu_core.sv
module cpu_core
import core_sizes_pkg::*, core_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        inst_valid_i,
    input  logic [31:0] inst_i,
    output logic        credit_o,
    output commit_t     commit_o
);

    logic [31:0]          head;
    logic                 not_empty;
    logic                 deq;
    logic                 rob_full;
    logic [ROB_IDX_W-1:0] rob_idx;
    logic [PREG_W-1:0]    rs1_preg;
    logic [PREG_W-1:0]    rs2_preg;
    logic [PREG_W-1:0]    commit_preg;
    logic [PREG_W-1:0]    free_preg;
    logic                 rs1_ready;
    logic                 rs2_ready;
    logic                 mul_tail_busy;
    logic                 free_valid;
    logic [31:0]          rs1_val;
    logic [31:0]          rs2_val;
    logic [31:0]          commit_val;
    cdb_t                 cdb;
    alloc_t               alloc;
    issue_t               issue;

    inst_queue inst_queue_i (
        .clk(clk), .rst(rst),
        .inst_valid_i(inst_valid_i), .inst_i(inst_i), .deq_i(deq),
        .head_o(head), .not_empty_o(not_empty), .credit_o(credit_o)
    );

    rename_dispatch rename_dispatch_i (
        .clk(clk), .rst(rst),
        .head_i(head), .not_empty_i(not_empty),
        .rob_full_i(rob_full), .rob_idx_i(rob_idx), .cdb_i(cdb),
        .rs1_ready_i(rs1_ready), .rs2_ready_i(rs2_ready),
        .rs1_val_i(rs1_val), .rs2_val_i(rs2_val),
        .mul_tail_busy_i(mul_tail_busy),
        .free_valid_i(free_valid), .free_preg_i(free_preg),
        .deq_o(deq), .rs1_preg_o(rs1_preg), .rs2_preg_o(rs2_preg),
        .alloc_o(alloc), .issue_o(issue)
    );

    // ready bit of the new destination drops at dispatch
    phys_regfile phys_regfile_i (
        .clk(clk), .rst(rst), .cdb_i(cdb),
        .rs1_preg_i(rs1_preg), .rs2_preg_i(rs2_preg),
        .clear_valid_i(alloc.valid), .clear_preg_i(alloc.entry.pd),
        .commit_preg_i(commit_preg),
        .rs1_val_o(rs1_val), .rs2_val_o(rs2_val),
        .rs1_ready_o(rs1_ready), .rs2_ready_o(rs2_ready),
        .commit_val_o(commit_val)
    );

    exec_units exec_units_i (
        .clk(clk), .rst(rst), .issue_i(issue),
        .cdb_o(cdb), .mul_tail_busy_o(mul_tail_busy)
    );

    rob rob_i (
        .clk(clk), .rst(rst),
        .alloc_i(alloc), .cdb_i(cdb), .commit_val_i(commit_val),
        .full_o(rob_full), .rob_idx_o(rob_idx), .commit_preg_o(commit_preg),
        .commit_o(commit_o), .free_valid_o(free_valid), .free_preg_o(free_preg)
    );

endmodule

// File: tb_cpu_core.sv
module tb_cpu_core
import core_sizes_pkg::*, core_types_pkg::*;
();

    localparam logic [6:0] F7_BASE  = 7'h00;
    localparam logic [6:0] F7_SUB   = 7'h20;
    localparam logic [6:0] F7_MUL   = 7'h01;
    localparam logic [2:0] F3_ADD   = 3'd0;
    localparam logic [2:0] F3_XOR   = 3'd4;
    localparam logic [2:0] F3_OR    = 3'd6;
    localparam logic [2:0] F3_AND   = 3'd7;
    localparam int         N_RANDOM = 200;

    logic        clk;
    logic        rst;
    logic        inst_valid_i;
    logic [31:0] inst_i;
    logic        credit_o;
    commit_t     commit_o;

    logic [31:0] arch [ARCH_REGS];      // architectural reference state
    commit_t     exp_q [$];
    int          n_sent;
    int          n_returned;
    int          n_commits;
    int          credits;
    int          cycles;
    int          errors;
    int          tests_run;
    int          tests_failed;
    integer      seed;

    cpu_core dut (
        .clk(clk), .rst(rst),
        .inst_valid_i(inst_valid_i), .inst_i(inst_i),
        .credit_o(credit_o), .commit_o(commit_o)
    );

    always #2 clk = ~clk;

    always_comb credits = QUEUE_DEPTH - n_sent + n_returned;

    always @(posedge clk) begin
        if (!rst && credit_o) begin
            n_returned <= n_returned + 1;
        end
    end

    // each commit against the model, in program order
    always @(posedge clk) begin
        commit_t e;
        if (!rst && commit_o.valid) begin
            n_commits <= n_commits + 1;
            if (exp_q.size() == 0) begin
                $display("commit seen with no instruction outstanding");
                errors++;
            end else begin
                e = exp_q.pop_front();
                a_commit_rd: assert (commit_o.rd == e.rd) else begin
                    $display("** Error: commit_o.rd = 0x%h, expected 0x%h", commit_o.rd, e.rd);
                    errors++;
                end
                a_commit_val: assert (commit_o.value == e.value) else begin
                    $display("** Error: commit_o.value = 0x%08h, expected 0x%08h (x%0d)",
                             commit_o.value, e.value, e.rd);
                    errors++;
                end
            end
        end
    end

    a_credit_range: assert property (@(posedge clk) disable iff (rst)
        credits >= 0 && credits <= QUEUE_DEPTH) else begin
        $display("** Error: credits = 0x%h, outside 0x0..0x%h", credits, QUEUE_DEPTH);
        errors++;
    end

    a_quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (!credit_o && !commit_o.valid)) else begin
        $display("credit_o or commit_o.valid high right after reset");
        errors++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 10 * n_sent + 100) begin
            $display("timeout after %0d cycles, %0d sent, %0d committed",
                     cycles, n_sent, n_commits);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    // rv32im semantics straight from the field encoding
    task automatic model_apply(input logic [31:0] inst);
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        commit_t     e;
        rd  = inst[11:7];
        a   = arch[inst[19:15]];
        b   = arch[inst[24:20]];
        res = '0;
        if (inst[6:0] == 7'b0010011) begin
            res = a + {{20{inst[31]}}, inst[31:20]};
        end else begin
            case ({inst[31:25], inst[14:12]})
                {F7_BASE, F3_ADD}: res = a + b;
                {F7_SUB, F3_ADD}:  res = a - b;
                {F7_MUL, F3_ADD}:  res = a * b;    // low word
                {F7_BASE, F3_XOR}: res = a ^ b;
                {F7_BASE, F3_OR}:  res = a | b;
                {F7_BASE, F3_AND}: res = a & b;
                default: begin
                    $display("reference model got an unsupported instruction 0x%08h", inst);
                    errors++;
                end
            endcase
        end
        if (rd != '0) begin
            arch[rd] = res;
        end
        e.valid = 1'b1;
        e.rd    = rd;
        e.value = (rd == '0) ? '0 : res;
        exp_q.push_back(e);
    endtask

    task automatic send_inst(input logic [31:0] inst);
        while (credits == 0) begin
            @(posedge clk);
            #1;
        end
        inst_valid_i = 1'b1;
        inst_i       = inst;
        n_sent++;
        model_apply(inst);
        @(posedge clk);
        #1;
        inst_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %-16s ok", name);
        end else begin
            $display("test %-16s %0d errors", name, errors - err_before);
            tests_failed++;
        end
    endtask

    initial begin
        int          err0;
        int          c0;
        int          r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        clk = 1'b0;
        rst = 1'b1;
        inst_valid_i = 1'b0;
        inst_i = '0;
        n_sent = 0;
        n_returned = 0;
        n_commits = 0;
        cycles = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        seed = 32'hd16f_64e8;
        for (int i = 0; i < ARCH_REGS; i++) begin
            arch[i] = '0;
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // more back-to-back sends than the queue holds
        err0 = errors;
        for (int i = 1; i <= 12; i++) begin
            send_inst(addi(i[4:0], 5'd0, 12'(i * 3)));
        end
        drain();
        a_credits_back: assert (n_returned == n_sent) else begin
            $display("** Error: returned credits = 0x%h, expected 0x%h", n_returned, n_sent);
            errors++;
        end
        report_test("credits", err0);

        err0 = errors;
        send_inst(addi(5'd1, 5'd0, 12'd100));
        send_inst(addi(5'd2, 5'd0, -12'sd7));
        send_inst(r_type(F7_BASE, F3_ADD, 5'd3, 5'd1, 5'd2));
        send_inst(r_type(F7_SUB, F3_ADD, 5'd4, 5'd1, 5'd2));
        send_inst(r_type(F7_BASE, F3_AND, 5'd5, 5'd1, 5'd2));
        send_inst(r_type(F7_BASE, F3_OR, 5'd6, 5'd1, 5'd2));
        send_inst(r_type(F7_BASE, F3_XOR, 5'd7, 5'd1, 5'd2));
        send_inst(addi(5'd8, 5'd7, 12'h7ff));
        drain();
        report_test("alu_ops", err0);

        // younger addis finish ahead of the mul
        err0 = errors;
        send_inst(r_type(F7_MUL, F3_ADD, 5'd9, 5'd1, 5'd2));
        send_inst(addi(5'd10, 5'd0, 12'd1));
        send_inst(addi(5'd11, 5'd0, 12'd2));
        send_inst(addi(5'd12, 5'd0, 12'd3));
        send_inst(addi(5'd13, 5'd1, 12'd5));
        drain();
        report_test("out_of_order", err0);

        err0 = errors;
        send_inst(r_type(F7_MUL, F3_ADD, 5'd14, 5'd1, 5'd1));
        send_inst(r_type(F7_BASE, F3_ADD, 5'd15, 5'd14, 5'd2));
        send_inst(r_type(F7_MUL, F3_ADD, 5'd16, 5'd15, 5'd15));
        send_inst(r_type(F7_SUB, F3_ADD, 5'd17, 5'd16, 5'd14));
        send_inst(r_type(F7_MUL, F3_ADD, 5'd14, 5'd17, 5'd3));
        send_inst(r_type(F7_BASE, F3_XOR, 5'd18, 5'd14, 5'd15));
        drain();
        report_test("raw_chain", err0);

        err0 = errors;
        send_inst(addi(5'd0, 5'd1, 12'd55));
        send_inst(r_type(F7_BASE, F3_ADD, 5'd0, 5'd1, 5'd2));
        send_inst(r_type(F7_BASE, F3_ADD, 5'd19, 5'd0, 5'd1));
        send_inst(addi(5'd20, 5'd0, -12'sd1));
        send_inst(r_type(F7_MUL, F3_ADD, 5'd0, 5'd1, 5'd1));
        send_inst(r_type(F7_BASE, F3_AND, 5'd21, 5'd0, 5'd20));
        drain();
        c0 = n_commits;
        for (int k = 0; k < N_RANDOM; k++) begin
            r   = $random(seed);
            rd  = r[4:0];
            rs1 = r[9:5];
            rs2 = r[14:10];
            case (r[31:27] % 7)
                0: send_inst(r_type(F7_BASE, F3_ADD, rd, rs1, rs2));
                1: send_inst(r_type(F7_SUB, F3_ADD, rd, rs1, rs2));
                2: send_inst(r_type(F7_BASE, F3_AND, rd, rs1, rs2));
                3: send_inst(r_type(F7_BASE, F3_OR, rd, rs1, rs2));
                4: send_inst(r_type(F7_BASE, F3_XOR, rd, rs1, rs2));
                5: send_inst(addi(rd, rs1, r[26:15]));
                default: send_inst(r_type(F7_MUL, F3_ADD, rd, rs1, rs2));
            endcase
        end
        drain();
        a_stress_count: assert (n_commits - c0 == N_RANDOM) else begin
            $display("** Error: random commits = 0x%h, expected 0x%h", n_commits - c0, N_RANDOM);
            errors++;
        end
        report_test("x0_and_stress", err0);

        $display("%0d tests run, %0d failed, %0d errors, %0d commits",
                 tests_run, tests_failed, errors, n_commits);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: all.f
core_sizes_pkg.sv
core_types_pkg.sv
inst_queue.sv
rename_dispatch.sv
phys_regfile.sv
exec_units.sv
rob.sv
cpu_core.sv
tb_cpu_core.sv

// File: Bender.yml
package:
  name: cpu_core

sources:
  - core_sizes_pkg.sv
  - core_types_pkg.sv
  - inst_queue.sv
  - rename_dispatch.sv
  - phys_regfile.sv
  - exec_units.sv
  - rob.sv
  - cpu_core.sv
  - target: test
    files:
      - tb_cpu_core.sv
